// File: rtl/ex_pkg.sv
// execute stage definitions
package ex_pkg;

    localparam int XLEN     = 32;
    localparam int REG_AW   = 5;
    localparam int SHAMT_W  = 5;
    localparam int ALU_OP_W = 5;

    typedef enum logic [6:0] {
        OPC_OP_IMM = 7'h13,
        OPC_OP     = 7'h33,
        OPC_BRANCH = 7'h63
    } opcode_e;

    // alu groups, register and immediate share these
    localparam logic [2:0] F3_ADD  = 3'b000; // ADD, SUB, ADDI
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101; // logical or arith by funct7[5]
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // branches
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    typedef enum logic [ALU_OP_W-1:0] {
        OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU, OP_XOR, OP_SRL, OP_SRA,
        OP_OR, OP_AND,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_NOP
    } alu_op_e;

    // op, op1, op2, rd, wb_en, target
    localparam int ENTRY_W = ALU_OP_W + 2 * XLEN + REG_AW + 1 + XLEN;

    localparam int QUEUE_DEPTH = 2;
    localparam int QPTR_W      = $clog2(QUEUE_DEPTH);
    localparam int QCNT_W      = $clog2(QUEUE_DEPTH + 1);

endpackage

// File: rtl/ex_decode.sv
// instruction decode stage
module ex_decode
    import ex_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n_i,

    input  logic              in_valid_i,
    output logic              in_ready_o,
    input  logic [XLEN-1:0]   inst_i,
    input  logic [XLEN-1:0]   inst_addr_i,
    input  logic [XLEN-1:0]   op1_i,
    input  logic [XLEN-1:0]   op2_i,

    output logic              dec_valid_o,
    input  logic              dec_ready_i,
    output alu_op_e           dec_op_o,
    output logic [XLEN-1:0]   dec_op1_o,
    output logic [XLEN-1:0]   dec_op2_o,
    output logic [REG_AW-1:0] dec_rd_o,
    output logic              dec_wb_en_o,
    output logic [XLEN-1:0]   dec_target_o
);

    opcode_e         opcode;
    logic [2:0]      funct3;
    logic            f7_b5;
    logic [XLEN-1:0] b_imm;
    alu_op_e         op_nxt;
    logic            wb_nxt;
    logic            load;

    assign opcode = opcode_e'(inst_i[6:0]);
    assign funct3 = inst_i[14:12];
    assign f7_b5  = inst_i[30];
    assign b_imm  = {{(XLEN-12){inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};

    assign in_ready_o = !dec_valid_o || dec_ready_i; // empty or draining
    assign load       = in_valid_i && in_ready_o;

    always_comb begin
        op_nxt = OP_NOP;
        wb_nxt = 1'b0;
        case (opcode)
            OPC_OP, OPC_OP_IMM: begin
                wb_nxt = 1'b1;
                case (funct3)
                    F3_ADD:  op_nxt = (f7_b5 && opcode == OPC_OP) ? OP_SUB : OP_ADD;
                    F3_SLL:  op_nxt = OP_SLL;
                    F3_SLT:  op_nxt = OP_SLT;
                    F3_SLTU: op_nxt = OP_SLTU;
                    F3_XOR:  op_nxt = OP_XOR;
                    F3_SR:   op_nxt = f7_b5 ? OP_SRA : OP_SRL;
                    F3_OR:   op_nxt = OP_OR;
                    F3_AND:  op_nxt = OP_AND;
                endcase
            end
            OPC_BRANCH: begin
                case (funct3)
                    F3_BEQ:  op_nxt = OP_BEQ;
                    F3_BNE:  op_nxt = OP_BNE;
                    F3_BLT:  op_nxt = OP_BLT;
                    F3_BGE:  op_nxt = OP_BGE;
                    F3_BLTU: op_nxt = OP_BLTU;
                    F3_BGEU: op_nxt = OP_BGEU;
                    default: op_nxt = OP_NOP; // funct3 2 and 3 unused
                endcase
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dec_valid_o <= 1'b0;
        end else if (in_ready_o) begin
            dec_valid_o <= in_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            dec_op_o     <= op_nxt;
            dec_op1_o    <= op1_i;
            dec_op2_o    <= op2_i;
            dec_rd_o     <= wb_nxt ? inst_i[11:7] : '0; // no dest without write-back
            dec_wb_en_o  <= wb_nxt;
            dec_target_o <= inst_addr_i + b_imm;
        end
    end

    a_dec_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        dec_valid_o && !dec_ready_i |=> dec_valid_o && $stable({dec_op_o, dec_op1_o,
            dec_op2_o, dec_rd_o, dec_wb_en_o, dec_target_o}));

endmodule

// File: rtl/ex_queue.sv
// two entry fifo
module ex_queue
    import ex_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n_i,

    input  logic               wr_valid_i,
    output logic               wr_ready_o,
    input  logic [ENTRY_W-1:0] wr_data_i,

    output logic               rd_valid_o,
    input  logic               rd_ready_i,
    output logic [ENTRY_W-1:0] rd_data_o
);

    logic [ENTRY_W-1:0] mem [QUEUE_DEPTH];
    logic [QPTR_W-1:0]  wr_ptr;
    logic [QPTR_W-1:0]  rd_ptr;
    logic [QCNT_W-1:0]  count;
    logic               wr_en;
    logic               rd_en;

    assign wr_ready_o = count < QUEUE_DEPTH;
    assign rd_valid_o = count != '0;
    assign rd_data_o  = mem[rd_ptr];

    assign wr_en = wr_valid_i && wr_ready_o;
    assign rd_en = rd_valid_o && rd_ready_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == QPTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == QPTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ; // both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data_i;
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n_i)
        count == QUEUE_DEPTH && !rd_en |=> count == QUEUE_DEPTH && $stable(wr_ptr));

    a_count_bound: assert property (@(posedge clk) disable iff (!rst_n_i)
        count <= QUEUE_DEPTH);

endmodule

// File: rtl/ex_alu.sv
// alu and branch unit
module ex_alu
    import ex_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n_i,

    input  logic              op_valid_i,
    output logic              op_ready_o,
    input  alu_op_e           op_i,
    input  logic [XLEN-1:0]   op1_i,
    input  logic [XLEN-1:0]   op2_i,
    input  logic [REG_AW-1:0] rd_i,
    input  logic              wb_en_i,
    input  logic [XLEN-1:0]   target_i,

    output logic              res_valid_o,
    input  logic              res_ready_i,
    output logic [XLEN-1:0]   res_data_o,
    output logic [REG_AW-1:0] res_rd_o,
    output logic              res_wb_en_o,
    output logic              jump_en_o,
    output logic [XLEN-1:0]   jump_addr_o
);

    logic [SHAMT_W-1:0] shamt;
    logic               eq;
    logic               lt_s;
    logic               lt_u;
    logic [XLEN-1:0]    data_nxt;
    logic               take;
    logic               load;

    assign shamt = op2_i[SHAMT_W-1:0];
    assign eq    = op1_i == op2_i;
    assign lt_s  = $signed(op1_i) < $signed(op2_i);
    assign lt_u  = op1_i < op2_i;

    assign op_ready_o = !res_valid_o || res_ready_i;
    assign load       = op_valid_i && op_ready_o;

    always_comb begin
        data_nxt = '0;
        take     = 1'b0;
        case (op_i)
            OP_ADD:  data_nxt = op1_i + op2_i;
            OP_SUB:  data_nxt = op1_i - op2_i;
            OP_SLL:  data_nxt = op1_i << shamt;
            OP_SLT:  data_nxt = {{(XLEN-1){1'b0}}, lt_s};
            OP_SLTU: data_nxt = {{(XLEN-1){1'b0}}, lt_u};
            OP_XOR:  data_nxt = op1_i ^ op2_i;
            OP_SRL:  data_nxt = op1_i >> shamt;
            OP_SRA:  data_nxt = $signed(op1_i) >>> shamt;
            OP_OR:   data_nxt = op1_i | op2_i;
            OP_AND:  data_nxt = op1_i & op2_i;
            OP_BEQ:  take = eq;
            OP_BNE:  take = !eq;
            OP_BLT:  take = lt_s;
            OP_BGE:  take = !lt_s;
            OP_BLTU: take = lt_u;
            OP_BGEU: take = !lt_u;
            default: ; // OP_NOP, all zero
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            res_valid_o <= 1'b0;
        end else if (op_ready_o) begin
            res_valid_o <= op_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            res_data_o  <= data_nxt;
            res_rd_o    <= rd_i;
            res_wb_en_o <= wb_en_i;
            jump_en_o   <= take;
            jump_addr_o <= take ? target_i : '0; // zero when not taken
        end
    end

    a_res_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        res_valid_o && !res_ready_i |=> res_valid_o && $stable({res_data_o, res_rd_o,
            res_wb_en_o, jump_en_o, jump_addr_o}));

endmodule

// File: rtl/ex_top.sv
// execute stage top
module ex_top
    import ex_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n_i,

    input  logic              in_valid_i,
    output logic              in_ready_o,
    input  logic [XLEN-1:0]   inst_i,
    input  logic [XLEN-1:0]   inst_addr_i,
    input  logic [XLEN-1:0]   op1_i,
    input  logic [XLEN-1:0]   op2_i,

    output logic              res_valid_o,
    input  logic              res_ready_i,
    output logic [XLEN-1:0]   res_data_o,
    output logic [REG_AW-1:0] res_rd_o,
    output logic              res_wb_en_o,
    output logic              jump_en_o,
    output logic [XLEN-1:0]   jump_addr_o
);

    // decode side
    logic                dec_valid;
    alu_op_e             dec_op;
    logic [XLEN-1:0]     dec_op1;
    logic [XLEN-1:0]     dec_op2;
    logic [REG_AW-1:0]   dec_rd;
    logic                dec_wb_en;
    logic [XLEN-1:0]     dec_target;
    logic                q_in_ready;
    logic [ENTRY_W-1:0]  q_wr_data;

    // alu side
    logic                q_valid;
    logic                q_ready;
    logic [ENTRY_W-1:0]  q_data;
    logic [ALU_OP_W-1:0] q_op_bits;
    alu_op_e             q_op;
    logic [XLEN-1:0]     q_op1;
    logic [XLEN-1:0]     q_op2;
    logic [REG_AW-1:0]   q_rd;
    logic                q_wb_en;
    logic [XLEN-1:0]     q_target;

    assign q_wr_data = {dec_op, dec_op1, dec_op2, dec_rd, dec_wb_en, dec_target};
    assign {q_op_bits, q_op1, q_op2, q_rd, q_wb_en, q_target} = q_data;
    assign q_op = alu_op_e'(q_op_bits);

    ex_decode u_decode (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .in_valid_i   (in_valid_i),
        .in_ready_o   (in_ready_o),
        .inst_i       (inst_i),
        .inst_addr_i  (inst_addr_i),
        .op1_i        (op1_i),
        .op2_i        (op2_i),
        .dec_valid_o  (dec_valid),
        .dec_ready_i  (q_in_ready),
        .dec_op_o     (dec_op),
        .dec_op1_o    (dec_op1),
        .dec_op2_o    (dec_op2),
        .dec_rd_o     (dec_rd),
        .dec_wb_en_o  (dec_wb_en),
        .dec_target_o (dec_target)
    );

    ex_queue u_queue (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .wr_valid_i (dec_valid),
        .wr_ready_o (q_in_ready),
        .wr_data_i  (q_wr_data),
        .rd_valid_o (q_valid),
        .rd_ready_i (q_ready),
        .rd_data_o  (q_data)
    );

    ex_alu u_alu (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .op_valid_i  (q_valid),
        .op_ready_o  (q_ready),
        .op_i        (q_op),
        .op1_i       (q_op1),
        .op2_i       (q_op2),
        .rd_i        (q_rd),
        .wb_en_i     (q_wb_en),
        .target_i    (q_target),
        .res_valid_o (res_valid_o),
        .res_ready_i (res_ready_i),
        .res_data_o  (res_data_o),
        .res_rd_o    (res_rd_o),
        .res_wb_en_o (res_wb_en_o),
        .jump_en_o   (jump_en_o),
        .jump_addr_o (jump_addr_o)
    );

endmodule

// File: include/ex_tb_ref.svh
// execute stage reference model
`ifndef EX_TB_REF_SVH
`define EX_TB_REF_SVH

function automatic logic ref_is_alu(input logic [XLEN-1:0] inst);
    return inst[6:0] == OPC_OP || inst[6:0] == OPC_OP_IMM;
endfunction

function automatic logic [REG_AW-1:0] ref_rd(input logic [XLEN-1:0] inst);
    return ref_is_alu(inst) ? inst[11:7] : '0;
endfunction

function automatic logic [XLEN-1:0] ref_data(input logic [XLEN-1:0] inst, a, b);
    logic [SHAMT_W-1:0] sh;
    sh = b[SHAMT_W-1:0]; // low five bits only
    if (!ref_is_alu(inst)) begin
        return '0;
    end
    case (inst[14:12])
        F3_ADD:  return (inst[30] && inst[6:0] == OPC_OP) ? a - b : a + b;
        F3_SLL:  return a << sh;
        F3_SLT:  return {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
        F3_SLTU: return {{(XLEN-1){1'b0}}, a < b};
        F3_XOR:  return a ^ b;
        F3_SR: begin
            if (inst[30]) begin
                return $signed(a) >>> sh;
            end
            return a >> sh;
        end
        F3_OR:   return a | b;
        default: return a & b;
    endcase
endfunction

function automatic logic ref_jump_en(input logic [XLEN-1:0] inst, a, b);
    if (inst[6:0] != OPC_BRANCH) begin
        return 1'b0;
    end
    case (inst[14:12])
        F3_BEQ:  return a == b;
        F3_BNE:  return a != b;
        F3_BLT:  return $signed(a) < $signed(b);
        F3_BGE:  return $signed(a) >= $signed(b);
        F3_BLTU: return a < b;
        F3_BGEU: return a >= b;
        default: return 1'b0;
    endcase
endfunction

function automatic logic [XLEN-1:0] ref_jump_addr(input logic [XLEN-1:0] inst, pc, a, b);
    logic [XLEN-1:0] imm;
    imm = {{(XLEN-12){inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    return ref_jump_en(inst, a, b) ? pc + imm : '0;
endfunction

`endif

// File: bench/ex_tb.sv
// execute stage testbench
module ex_tb
    import ex_pkg::*;
;

`include "ex_tb_ref.svh"

    localparam int WAIT_LIMIT = 100;

    logic              clk;
    logic              rst_n_i;
    logic              in_valid_i;
    logic              in_ready_o;
    logic [XLEN-1:0]   inst_i;
    logic [XLEN-1:0]   inst_addr_i;
    logic [XLEN-1:0]   op1_i;
    logic [XLEN-1:0]   op2_i;
    logic              res_valid_o;
    logic              res_ready_i;
    logic [XLEN-1:0]   res_data_o;
    logic [REG_AW-1:0] res_rd_o;
    logic              res_wb_en_o;
    logic              jump_en_o;
    logic [XLEN-1:0]   jump_addr_o;

    // data, rd, wb_en, jump_en, jump_addr
    logic [2*XLEN+REG_AW+1:0] sb_q [$];
    logic [2*XLEN+REG_AW+1:0] exp_head = '0;
    logic [2*XLEN+REG_AW+1:0] res_beat;
    logic                     sb_empty = 1'b1;
    logic                     stall_mode = 1'b0;
    logic                     timed_out = 1'b0;
    int                       errors = 0;
    int                       tests_run = 0;
    int                       tests_failed = 0;
    int                       beats_sent = 0;
    int                       beats_recv = 0;

    ex_top dut (.*);

    assign res_beat = {res_data_o, res_rd_o, res_wb_en_o, jump_en_o, jump_addr_o};

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // random stalls only in back-pressure mode
    task automatic drive_res_ready();
        forever begin
            @(posedge clk);
            #1;
            res_ready_i = stall_mode ? ($urandom_range(1, 0) == 1) : 1'b1;
        end
    endtask

    function automatic logic [2*XLEN+REG_AW+1:0] predict_beat(input logic [XLEN-1:0] inst,
            pc, a, b);
        return {ref_data(inst, a, b), ref_rd(inst), ref_is_alu(inst), ref_jump_en(inst, a, b),
            ref_jump_addr(inst, pc, a, b)};
    endfunction

    // pop before push so a same-edge pair keeps order
    always @(posedge clk) begin
        if (rst_n_i && res_valid_o && res_ready_i) begin
            beats_recv++;
            if (sb_q.size() != 0) begin
                void'(sb_q.pop_front());
            end
        end
        if (rst_n_i && in_valid_i && in_ready_o) begin
            sb_q.push_back(predict_beat(inst_i, inst_addr_i, op1_i, op2_i));
        end
        sb_empty = sb_q.size() == 0;
        exp_head = sb_empty ? '0 : sb_q[0];
    end

    a_reset: assert property (@(posedge clk) $rose(rst_n_i) |-> !res_valid_o && in_ready_o)
        else begin
            errors++;
            $display("CHECK FAILED at %0t: res_valid_o or in_ready_o wrong after reset", $time);
        end

    a_result: assert property (@(posedge clk) disable iff (!rst_n_i)
        res_valid_o && res_ready_i |-> !sb_empty && res_beat == exp_head)
        else begin
            errors++;
            $display("CHECK FAILED at %0t: result %h, expected %h (empty %0b)", $time,
                res_beat, exp_head, sb_empty);
        end

    a_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        res_valid_o && !res_ready_i |=> res_valid_o && $stable(res_beat))
        else begin
            errors++;
            $display("CHECK FAILED at %0t: result changed while stalled", $time);
        end

    function automatic logic [XLEN-1:0] build_inst(input logic [6:0] opc, input logic [2:0] f3,
            input logic alt);
        logic [XLEN-1:0] inst;
        inst        = $urandom();
        inst[6:0]   = opc;
        inst[14:12] = f3;
        if (opc == OPC_OP || (opc == OPC_OP_IMM && (f3 == F3_SLL || f3 == F3_SR))) begin
            inst[31:25] = alt ? 7'b0100000 : 7'b0000000;
        end
        return inst;
    endfunction

    // called 1 unit after an edge and returns 1 unit after the accepting edge
    task automatic send_beat(input logic [XLEN-1:0] inst, a, b);
        int waited;
        if (timed_out) return;
        in_valid_i  = 1'b1;
        inst_i      = inst;
        inst_addr_i = $urandom() & 32'hffff_fffc;
        op1_i       = a;
        op2_i       = b;
        waited      = 0;
        while (!in_ready_o && waited < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!in_ready_o) begin
            $display("timeout: input beat not accepted within %0d cycles", WAIT_LIMIT);
            timed_out  = 1'b1;
            in_valid_i = 1'b0;
            return;
        end
        @(posedge clk);
        #1;
        in_valid_i = 1'b0;
        beats_sent++;
    endtask

    task automatic wait_drain();
        int waited;
        if (timed_out) return;
        waited = 0;
        while (sb_q.size() != 0 && waited < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (sb_q.size() != 0) begin
            $display("timeout: %0d results never came out of the DUT", sb_q.size());
            timed_out = 1'b1;
        end
    endtask

    task automatic send_reg(input logic [2:0] f3, input logic alt);
        send_beat(build_inst(OPC_OP, f3, alt), $urandom(), $urandom());
    endtask

    task automatic send_imm(input logic [2:0] f3, input logic alt);
        logic [XLEN-1:0] inst;
        logic [XLEN-1:0] imm;
        inst = build_inst(OPC_OP_IMM, f3, alt);
        imm  = {{(XLEN-12){inst[31]}}, inst[31:20]};
        if (f3 == F3_SLL || f3 == F3_SR) begin
            imm = $urandom(); // upper bits must not matter
        end
        send_beat(inst, $urandom(), imm);
    endtask

    // pair 0 equal, 1 less both ways, 2 less signed only
    task automatic send_branch(input logic [2:0] f3, input int pair);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        a = (pair == 2) ? 32'hffff_fffd : 32'd5;
        b = (pair == 0) ? 32'd5 : (pair == 1) ? 32'd9 : 32'd4;
        send_beat(build_inst(OPC_BRANCH, f3, 1'b0), a, b);
    endtask

    task automatic send_unknown();
        logic [6:0] opc;
        opc = 7'($urandom());
        if (opc == OPC_OP || opc == OPC_OP_IMM || opc == OPC_BRANCH) begin
            opc = opc ^ 7'h04; // lands on auipc, lui or jalr
        end
        if ($urandom_range(1, 0) == 0) begin
            send_beat(build_inst(OPC_BRANCH, {2'b01, 1'($urandom())}, 1'b0), $urandom(),
                $urandom());
        end else begin
            send_beat(build_inst(opc, 3'($urandom()), 1'b0), $urandom(), $urandom());
        end
    endtask

    task automatic end_test(input string name, input int e0);
        tests_run++;
        if (errors != e0 || timed_out) begin
            tests_failed++;
            $display("test %s: FAILED with %0d errors", name, errors - e0);
        end else begin
            $display("test %s: ok, %0d beats so far", name, beats_recv);
        end
    endtask

    initial begin
        logic [2:0] br_f3 [6];
        int         e0;
        void'($urandom(32'he7a0));
        br_f3       = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
        rst_n_i     = 1'b0;
        in_valid_i  = 1'b0;
        inst_i      = '0;
        inst_addr_i = '0;
        op1_i       = '0;
        op2_i       = '0;
        res_ready_i = 1'b1;
        fork
            drive_res_ready();
        join_none
        repeat (2) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        @(posedge clk);
        #1;
        end_test("reset", 0);

        e0 = errors;
        for (int i = 0; i < 10; i++) begin
            for (int r = 0; r < 6; r++) begin
                send_reg((i < 8) ? 3'(i) : ((i == 8) ? F3_ADD : F3_SR), i >= 8);
            end
        end
        wait_drain();
        end_test("register ops", e0);

        e0 = errors;
        for (int i = 0; i < 9; i++) begin
            for (int r = 0; r < 6; r++) begin
                send_imm((i < 8) ? 3'(i) : F3_SR, i == 8); // last pass is srai
            end
        end
        wait_drain();
        end_test("immediate ops", e0);

        e0 = errors;
        for (int i = 0; i < 6; i++) begin
            for (int p = 0; p < 6; p++) begin
                send_branch(br_f3[i], p % 3);
            end
        end
        wait_drain();
        end_test("branches", e0);

        e0 = errors;
        for (int n = 0; n < 16; n++) begin
            send_unknown();
        end
        wait_drain();
        end_test("unknown", e0);

        e0 = errors;
        stall_mode = 1'b1;
        for (int n = 0; n < 200; n++) begin
            case ($urandom_range(3, 0))
                0: send_reg(3'($urandom()), 1'($urandom()));
                1: send_imm(3'($urandom()), 1'($urandom()));
                2: send_branch(br_f3[$urandom_range(5, 0)], $urandom_range(2, 0));
                default: send_unknown();
            endcase
            if ($urandom_range(3, 0) == 0) begin
                @(posedge clk);
                #1;
            end
        end
        wait_drain();
        stall_mode = 1'b0;
        a_drained: assert (sb_q.size() == 0 && beats_recv == beats_sent)
            else begin
                errors++;
                $display("CHECK FAILED at %0t: %0d sent, %0d received, %0d outstanding",
                    $time, beats_sent, beats_recv, sb_q.size());
            end
        end_test("back-pressure", e0);

        $display("%0d tests, %0d failed, %0d beats sent, %0d checked, %0d errors",
            tests_run, tests_failed, beats_sent, beats_recv, errors);
        if (errors == 0 && tests_failed == 0 && !timed_out) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+include
rtl/ex_pkg.sv
rtl/ex_decode.sv
rtl/ex_queue.sv
rtl/ex_alu.sv
rtl/ex_top.sv
bench/ex_tb.sv

// File: Bender.yml
package:
  name: ex_stage

sources:
  - files:
      - rtl/ex_pkg.sv
      - rtl/ex_decode.sv
      - rtl/ex_queue.sv
      - rtl/ex_alu.sv
      - rtl/ex_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/ex_tb.sv
